/* logic/isa_pkg.sv */
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by issue
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // Shared by OP and OP-IMM
    typedef enum logic [2:0] {
        add  = 3'b000,  // Also sub with funct7[5]
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,  // srl or sra
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } i_format_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        opcode_e               opcode;
    } s_format_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } u_format_t;

    // One instruction word, several views
    typedef union packed {
        r_format_t        r;
        i_format_t        i;
        s_format_t        s;
        u_format_t        u;
        logic [XLEN-1:0]  raw;
    } instr_u;

endpackage

/* logic/tomasulo_pkg.sv */
package tomasulo_pkg;

    import isa_pkg::*;

    localparam int ROB_TAG_W = 3;
    localparam int ROB_DEPTH = 8;  // Tag 0 reserved for "no producer"

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        logic [XLEN-1:0] value;
        logic            valid;
        rob_tag_t        tag;
    } operand_t;

    // Low three bits follow funct3, bit 3 is the funct7[5] variant
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        operand_t rs1;
        operand_t rs2;
        rob_tag_t rob_idx;
    } alu_entry_t;

    typedef struct packed {
        logic     valid;
        logic     is_unsigned;  // sltu / sltiu
        operand_t rs1;
        operand_t rs2;
        rob_tag_t rob_idx;
    } cmp_entry_t;

    typedef struct packed {
        logic            valid;
        logic            is_store;
        logic [2:0]      funct3;  // Access size and sign
        operand_t        base;
        operand_t        data;
        logic [XLEN-1:0] offset;
        rob_tag_t        rob_idx;
    } lsb_entry_t;

    typedef struct packed {
        logic [XLEN-1:0] vj;
        rob_tag_t        qj;
        logic [XLEN-1:0] vk;
        rob_tag_t        qk;
    } regfile_read_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] value;
    } rob_result_t;

    typedef rob_result_t [ROB_DEPTH-1:0] rob_results_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
    } rob_alloc_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        rob_tag_t              tag;
    } rename_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } queue_entry_t;

    typedef enum logic [1:0] {
        unit_none,
        unit_alu,
        unit_cmp,
        unit_lsb
    } unit_e;

endpackage

/* logic/operand_bypass.sv */
module operand_bypass
    import tomasulo_pkg::*;
(
    input  logic [31:0]  value_i,
    input  rob_tag_t     tag_i,
    input  rob_results_t rob_results_i,
    output operand_t     operand_o
);

    logic        has_producer;
    rob_result_t producer;

    assign has_producer = (tag_i != '0);
    assign producer     = rob_results_i[tag_i];

    always_comb begin
        if (has_producer && producer.ready) begin
            // Result already finished, take it from the ROB
            operand_o.value = producer.value;
            operand_o.valid = 1'b1;
            operand_o.tag   = '0;
        end else begin
            operand_o.value = value_i;
            operand_o.valid = !has_producer;  // Still waiting on tag_i
            operand_o.tag   = tag_i;
        end
    end

endmodule

/* logic/instr_decoder.sv */
module instr_decoder
    import isa_pkg::*, tomasulo_pkg::*;
(
    input  queue_entry_t          entry_i,
    input  operand_t              rs1_op_i,
    input  operand_t              rs2_op_i,
    output unit_e                 unit_o,
    output logic                  discard_o,
    output logic                  writes_rd_o,
    output alu_entry_t            alu_o,
    output cmp_entry_t            cmp_o,
    output lsb_entry_t            lsb_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o
);

    instr_u                instr;
    opcode_e               opcode;
    arith_funct3_e         funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       i_imm;
    logic [XLEN-1:0]       s_imm;
    logic [XLEN-1:0]       u_imm;
    logic                  is_cmp;
    logic                  alt;
    logic                  known;
    operand_t              src2;

    // Operand that needs no producer
    function automatic operand_t imm_operand(input logic [XLEN-1:0] value);
        operand_t op;
        op.value = value;
        op.valid = 1'b1;
        op.tag   = '0;
        return op;
    endfunction

    assign instr  = entry_i.instr;
    assign opcode = instr.r.opcode;
    assign funct3 = arith_funct3_e'(instr.r.funct3);
    assign rd     = instr.r.rd;
    assign rs1_o  = instr.r.rs1;
    assign rs2_o  = instr.r.rs2;

    assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign s_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign u_imm = {instr.u.imm, 12'h000};

    assign is_cmp = (funct3 == slt) || (funct3 == sltu);

    // funct7[5] picks sub only for register ops, sra for both
    assign alt = instr.r.funct7[5] && ((funct3 == sr) || (opcode == op_reg && funct3 == add));

    assign src2 = (opcode == op_reg) ? rs2_op_i : imm_operand(i_imm);

    always_comb begin
        unit_o = unit_none;
        known  = 1'b1;
        alu_o  = '0;
        cmp_o  = '0;
        lsb_o  = '0;

        case (opcode)
            op_lui: begin
                unit_o    = unit_alu;
                alu_o.op  = alu_add;
                alu_o.rs1 = imm_operand('0);
                alu_o.rs2 = imm_operand(u_imm);
            end
            op_auipc: begin
                unit_o    = unit_alu;
                alu_o.op  = alu_add;
                alu_o.rs1 = imm_operand(entry_i.pc);
                alu_o.rs2 = imm_operand(u_imm);
            end
            op_imm, op_reg: begin
                if (is_cmp) begin
                    unit_o            = unit_cmp;
                    cmp_o.is_unsigned = (funct3 == sltu);
                    cmp_o.rs1         = rs1_op_i;
                    cmp_o.rs2         = src2;
                end else begin
                    unit_o    = unit_alu;
                    alu_o.op  = alu_op_e'({alt, funct3});
                    alu_o.rs1 = rs1_op_i;
                    alu_o.rs2 = src2;
                end
            end
            op_load: begin
                unit_o         = unit_lsb;
                lsb_o.is_store = 1'b0;
                lsb_o.funct3   = funct3;
                lsb_o.base     = rs1_op_i;
                lsb_o.data     = imm_operand('0);  // Unused by loads
                lsb_o.offset   = i_imm;
            end
            op_store: begin
                unit_o         = unit_lsb;
                lsb_o.is_store = 1'b1;
                lsb_o.funct3   = funct3;
                lsb_o.base     = rs1_op_i;
                lsb_o.data     = rs2_op_i;
                lsb_o.offset   = s_imm;
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign writes_rd_o = known && (opcode != op_store);

    // Stores have no rd, so they are never dropped for x0
    assign discard_o = !known || (writes_rd_o && rd == '0);

endmodule

/* logic/issue_control.sv */
module issue_control
    import tomasulo_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         iq_empty_i,
    input  rob_tag_t     rob_free_tag_i,
    input  logic         alu_full_i,
    input  logic         cmp_full_i,
    input  logic         lsb_full_i,
    input  queue_entry_t entry_i,
    input  unit_e        unit_i,
    input  logic         discard_i,
    input  logic         writes_rd_i,
    input  alu_entry_t   alu_i,
    input  cmp_entry_t   cmp_i,
    input  lsb_entry_t   lsb_i,
    output logic         iq_read_o,
    output alu_entry_t   alu_o,
    output cmp_entry_t   cmp_o,
    output lsb_entry_t   lsb_o,
    output rob_alloc_t   rob_o,
    output rename_t      rename_o
);

    logic unit_full;
    logic accept;
    logic dispatch;

    always_comb begin
        case (unit_i)
            unit_alu: unit_full = alu_full_i;
            unit_cmp: unit_full = cmp_full_i;
            unit_lsb: unit_full = lsb_full_i;
            default:  unit_full = 1'b1;
        endcase
    end

    // Discarded heads are popped without needing a tag or a slot
    assign accept    = !iq_empty_i && (discard_i || (rob_free_tag_i != '0 && !unit_full));
    assign dispatch  = accept && !discard_i;
    assign iq_read_o = accept;

    always_ff @(posedge clk) begin
        if (dispatch) begin
            alu_o         <= alu_i;
            alu_o.rob_idx <= rob_free_tag_i;
            cmp_o         <= cmp_i;
            cmp_o.rob_idx <= rob_free_tag_i;
            lsb_o         <= lsb_i;
            lsb_o.rob_idx <= rob_free_tag_i;

            rob_o.pc     <= entry_i.pc;
            rob_o.opcode <= entry_i.instr.r.opcode;
            rob_o.rd     <= writes_rd_i ? entry_i.instr.r.rd : '0;  // Stores carry no rd

            rename_o.rd  <= entry_i.instr.r.rd;
            rename_o.tag <= rob_free_tag_i;
        end
        // Overrides the valid copied with each entry
        if (rst) begin
            alu_o.valid    <= 1'b0;
            cmp_o.valid    <= 1'b0;
            lsb_o.valid    <= 1'b0;
            rob_o.valid    <= 1'b0;
            rename_o.valid <= 1'b0;
        end else begin
            alu_o.valid    <= dispatch && (unit_i == unit_alu);
            cmp_o.valid    <= dispatch && (unit_i == unit_cmp);
            lsb_o.valid    <= dispatch && (unit_i == unit_lsb);
            rob_o.valid    <= dispatch;
            rename_o.valid <= dispatch && writes_rd_i;
        end
    end

endmodule

/* logic/issue_stage.sv */
module issue_stage
    import isa_pkg::*, tomasulo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  queue_entry_t          iq_entry_i,
    input  logic                  iq_empty_i,
    output logic                  iq_read_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    input  regfile_read_t         regfile_i,
    input  rob_tag_t              rob_free_tag_i,
    input  rob_results_t          rob_results_i,
    input  logic                  alu_full_i,
    input  logic                  cmp_full_i,
    input  logic                  lsb_full_i,
    output alu_entry_t            alu_o,
    output cmp_entry_t            cmp_o,
    output lsb_entry_t            lsb_o,
    output rob_alloc_t            rob_o,
    output rename_t               rename_o
);

    operand_t   rs1_op;
    operand_t   rs2_op;
    unit_e      unit;
    logic       discard;
    logic       writes_rd;
    alu_entry_t dec_alu;
    cmp_entry_t dec_cmp;
    lsb_entry_t dec_lsb;

    operand_bypass u_rs1_bypass (
        .value_i       (regfile_i.vj),
        .tag_i         (regfile_i.qj),
        .rob_results_i (rob_results_i),
        .operand_o     (rs1_op)
    );

    operand_bypass u_rs2_bypass (
        .value_i       (regfile_i.vk),
        .tag_i         (regfile_i.qk),
        .rob_results_i (rob_results_i),
        .operand_o     (rs2_op)
    );

    instr_decoder u_decoder (
        .entry_i     (iq_entry_i),
        .rs1_op_i    (rs1_op),
        .rs2_op_i    (rs2_op),
        .unit_o      (unit),
        .discard_o   (discard),
        .writes_rd_o (writes_rd),
        .alu_o       (dec_alu),
        .cmp_o       (dec_cmp),
        .lsb_o       (dec_lsb),
        .rs1_o       (rs1_o),
        .rs2_o       (rs2_o)
    );

    issue_control u_control (
        .clk            (clk),
        .rst            (rst),
        .iq_empty_i     (iq_empty_i),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .entry_i        (iq_entry_i),
        .unit_i         (unit),
        .discard_i      (discard),
        .writes_rd_i    (writes_rd),
        .alu_i          (dec_alu),
        .cmp_i          (dec_cmp),
        .lsb_i          (dec_lsb),
        .iq_read_o      (iq_read_o),
        .alu_o          (alu_o),
        .cmp_o          (cmp_o),
        .lsb_o          (lsb_o),
        .rob_o          (rob_o),
        .rename_o       (rename_o)
    );

endmodule

/* tests/issue_stage_properties.sv */
module issue_stage_properties
    import isa_pkg::*, tomasulo_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input queue_entry_t          iq_entry_i,
    input logic                  iq_empty_i,
    input logic                  iq_read_o,
    input logic [REG_ADDR_W-1:0] rs1_o,
    input logic [REG_ADDR_W-1:0] rs2_o,
    input regfile_read_t         regfile_i,
    input rob_tag_t              rob_free_tag_i,
    input rob_results_t          rob_results_i,
    input logic                  alu_full_i,
    input logic                  cmp_full_i,
    input logic                  lsb_full_i,
    input alu_entry_t            alu_o,
    input cmp_entry_t            cmp_o,
    input lsb_entry_t            lsb_o,
    input rob_alloc_t            rob_o,
    input rename_t               rename_o
);

    logic        fail_seen = 1'b0;
    logic [31:0] word;
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] u_imm;
    logic        known;
    logic        discard;
    logic        target_full;
    logic        accept;
    logic        dispatch;
    logic        any_valid;
    logic [4:0]  exp_valids;
    logic [4:0]  got_valids;
    unit_e       target;
    operand_t    op1;
    operand_t    op2;
    alu_entry_t  exp_alu;
    cmp_entry_t  exp_cmp;
    lsb_entry_t  exp_lsb;
    rob_alloc_t  exp_rob;
    rename_t     exp_ren;

    task automatic note_failure(input string msg);
        $error("%s", msg);
        fail_seen = 1'b1;
    endtask

    function automatic operand_t resolve(input logic [31:0] value, input rob_tag_t tag,
                                         input rob_results_t results);
        operand_t op;
        if (tag != 3'd0 && results[tag].ready) begin
            op.value = results[tag].value;
            op.valid = 1'b1;
            op.tag   = 3'd0;
        end else begin
            op.value = value;
            op.valid = (tag == 3'd0);
            op.tag   = tag;
        end
        return op;
    endfunction

    function automatic operand_t fixed(input logic [31:0] value);
        operand_t op;
        op.value = value;
        op.valid = 1'b1;
        op.tag   = 3'd0;
        return op;
    endfunction

    assign word  = iq_entry_i.instr.raw;
    assign opc   = word[6:0];
    assign rd    = word[11:7];
    assign f3    = word[14:12];
    assign i_imm = {{20{word[31]}}, word[31:20]};
    assign s_imm = {{20{word[31]}}, word[31:25], word[11:7]};
    assign u_imm = {word[31:12], 12'h000};
    assign op1   = resolve(regfile_i.vj, regfile_i.qj, rob_results_i);
    assign op2   = resolve(regfile_i.vk, regfile_i.qk, rob_results_i);

    always_comb begin
        target  = unit_none;
        exp_alu = '0;
        exp_cmp = '0;
        exp_lsb = '0;
        case (opc)
            op_lui, op_auipc: begin
                target      = unit_alu;
                exp_alu.op  = alu_add;
                exp_alu.rs1 = fixed((opc == op_lui) ? 32'h0 : iq_entry_i.pc);
                exp_alu.rs2 = fixed(u_imm);
            end
            op_imm, op_reg: begin
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    target              = unit_cmp;
                    exp_cmp.is_unsigned = f3[0];
                    exp_cmp.rs1         = op1;
                    exp_cmp.rs2         = (opc == op_reg) ? op2 : fixed(i_imm);
                end else begin
                    target = unit_alu;
                    if (word[30] && f3 == 3'b101)
                        exp_alu.op = alu_sra;
                    else if (word[30] && f3 == 3'b000 && opc == op_reg)
                        exp_alu.op = alu_sub;  // addi ignores bit 30
                    else
                        exp_alu.op = alu_op_e'({1'b0, f3});
                    exp_alu.rs1 = op1;
                    exp_alu.rs2 = (opc == op_reg) ? op2 : fixed(i_imm);
                end
            end
            op_load, op_store: begin
                target           = unit_lsb;
                exp_lsb.is_store = (opc == op_store);
                exp_lsb.funct3   = f3;
                exp_lsb.base     = op1;
                exp_lsb.data     = (opc == op_store) ? op2 : fixed(32'h0);
                exp_lsb.offset   = (opc == op_store) ? s_imm : i_imm;
            end
            default: ;
        endcase
        // Entries as they should look if dispatched
        exp_alu.valid   = 1'b1;
        exp_alu.rob_idx = rob_free_tag_i;
        exp_cmp.valid   = 1'b1;
        exp_cmp.rob_idx = rob_free_tag_i;
        exp_lsb.valid   = 1'b1;
        exp_lsb.rob_idx = rob_free_tag_i;
        exp_rob.valid   = 1'b1;
        exp_rob.pc      = iq_entry_i.pc;
        exp_rob.opcode  = opcode_e'(opc);
        exp_rob.rd      = (opc == op_store) ? 5'd0 : rd;
        exp_ren.valid   = 1'b1;
        exp_ren.rd      = rd;
        exp_ren.tag     = rob_free_tag_i;
    end

    always_comb begin
        case (target)
            unit_alu: target_full = alu_full_i;
            unit_cmp: target_full = cmp_full_i;
            unit_lsb: target_full = lsb_full_i;
            default:  target_full = 1'b1;
        endcase
    end

    assign known    = (target != unit_none);
    assign discard  = !known || (opc != op_store && rd == 5'd0);
    assign accept   = !iq_empty_i && (discard || (rob_free_tag_i != 3'd0 && !target_full));
    assign dispatch = accept && !discard;

    assign exp_valids = {dispatch && target == unit_alu, dispatch && target == unit_cmp,
                         dispatch && target == unit_lsb, dispatch, dispatch && opc != op_store};
    assign got_valids = {alu_o.valid, cmp_o.valid, lsb_o.valid, rob_o.valid, rename_o.valid};
    assign any_valid  = |got_valids;

    a_reset: assert property (@(posedge clk) rst |=> !any_valid)
        else note_failure("valid output in the cycle after reset");
    a_idle: assert property (@(posedge clk) disable iff (rst) !iq_read_o |=> !any_valid)
        else note_failure("valid output after a cycle without iq_read_o");
    a_read: assert property (@(posedge clk) disable iff (rst) iq_read_o == accept)
        else note_failure("iq_read_o disagrees with the acceptance rule");
    a_regs: assert property (@(posedge clk) disable iff (rst)
            rs1_o == word[19:15] && rs2_o == word[24:20])
        else note_failure("register file read address mismatch");
    a_valids: assert property (@(posedge clk) disable iff (rst) got_valids == $past(exp_valids))
        else note_failure("wrong set of dispatch, ROB or rename valids");
    a_alu: assert property (@(posedge clk) disable iff (rst)
            !alu_o.valid || alu_o == $past(exp_alu))
        else note_failure("ALU entry mismatch");
    a_cmp: assert property (@(posedge clk) disable iff (rst)
            !cmp_o.valid || cmp_o == $past(exp_cmp))
        else note_failure("compare entry mismatch");
    a_lsb: assert property (@(posedge clk) disable iff (rst)
            !lsb_o.valid || lsb_o == $past(exp_lsb))
        else note_failure("load-store entry mismatch");
    a_rob: assert property (@(posedge clk) disable iff (rst)
            !rob_o.valid || rob_o == $past(exp_rob))
        else note_failure("ROB allocation mismatch");
    a_rename: assert property (@(posedge clk) disable iff (rst)
            !rename_o.valid || rename_o == $past(exp_ren))
        else note_failure("rename mismatch");

endmodule

bind issue_stage issue_stage_properties u_props (.*);

/* tests/issue_stage_tb.sv */
module issue_stage_tb
    import isa_pkg::*, tomasulo_pkg::*;
();

    localparam int N_INSTR = 400;
    localparam int TIMEOUT = 10 * N_INSTR;  // Cycles

    logic          clk;
    logic          rst;
    queue_entry_t  iq_entry;
    logic          iq_empty;
    logic          iq_read;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    regfile_read_t regfile;
    rob_tag_t      free_tag;
    rob_results_t  rob_results;
    logic          alu_full;
    logic          cmp_full;
    logic          lsb_full;
    alu_entry_t    alu;
    cmp_entry_t    cmp;
    lsb_entry_t    lsb;
    rob_alloc_t    rob;
    rename_t       rename;
    logic [31:0]   rng;
    logic [31:0]   salt;
    int            head;
    int            cycle_count;
    queue_entry_t  program_q [N_INSTR];

    issue_stage DUT (
        .clk            (clk),
        .rst            (rst),
        .iq_entry_i     (iq_entry),
        .iq_empty_i     (iq_empty),
        .iq_read_o      (iq_read),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .regfile_i      (regfile),
        .rob_free_tag_i (free_tag),
        .rob_results_i  (rob_results),
        .alu_full_i     (alu_full),
        .cmp_full_i     (cmp_full),
        .lsb_full_i     (lsb_full),
        .alu_o          (alu),
        .cmp_o          (cmp),
        .lsb_o          (lsb),
        .rob_o          (rob),
        .rename_o       (rename)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Value and producer tag for one register
    function automatic logic [34:0] reg_reply(input logic [4:0] idx, input logic [31:0] seed);
        logic [31:0] h;
        logic [31:0] t;
        h = xorshift(seed + 32'(idx) * 32'h9e37_79b9);
        t = xorshift(h);
        if (idx == 5'd0)
            return '0;
        return {h, t[3] ? t[2:0] : 3'd0};
    endfunction

    function automatic logic [31:0] make_instr(input logic [31:0] r);
        logic [31:0] word;
        logic [6:0]  opc;
        word = xorshift(r ^ 32'h1357_9bdf);
        case (r[3:0])
            4'd0:                      opc = op_lui;
            4'd1:                      opc = op_auipc;
            4'd2, 4'd3:                opc = op_load;
            4'd4, 4'd5:                opc = op_store;
            4'd6, 4'd7, 4'd8:          opc = op_imm;
            4'd9, 4'd10, 4'd11, 4'd12: opc = op_reg;
            4'd13:                     opc = 7'b1101111;  // JAL
            4'd14:                     opc = 7'b1100011;  // Branch
            default:                   opc = 7'b0001111;  // Fence
        endcase
        word[6:0] = opc;
        if (opc == op_reg)
            word[31:25] = {1'b0, r[8], 5'b0};
        if (r[11:9] == 3'd0)
            word[11:7] = 5'd0;  // Extra x0 targets
        return word;
    endfunction

    task automatic drive_next_cycle();
        rng = xorshift(rng);
        if (head < N_INSTR)
            iq_entry <= program_q[head];
        iq_empty <= (head >= N_INSTR) || (rng[2:0] == 3'd0);
        free_tag <= rng[5:3];  // Zero means no free ROB entry
        alu_full <= (rng[7:6] == 2'b11);
        cmp_full <= (rng[9:8] == 2'b11);
        lsb_full <= (rng[11:10] == 2'b11);
        salt     <= xorshift(rng ^ 32'h0000_c0de);
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rng = xorshift(rng);
            rob_results[i] <= {rng[0], xorshift(rng ^ 32'h5a5a_a5a5)};
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Register file answers the read addresses in the same cycle
    always_comb begin
        {regfile.vj, regfile.qj} = reg_reply(rs1, salt);
        {regfile.vk, regfile.qk} = reg_reply(rs2, ~salt);
    end

    initial begin
        rng = 32'd56;
        for (int i = 0; i < N_INSTR; i++) begin
            rng = xorshift(rng);
            program_q[i].pc        = 32'h0000_1000 + 32'(4 * i);
            program_q[i].instr.raw = make_instr(rng);
        end
        head = 0;
        rst         <= 1'b1;
        iq_empty    <= 1'b1;
        iq_entry    <= program_q[0];
        free_tag    <= '0;
        alu_full    <= 1'b0;
        cmp_full    <= 1'b0;
        lsb_full    <= 1'b0;
        rob_results <= '0;
        salt        <= 32'd56;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (head < N_INSTR) begin
            @(posedge clk);
            if (iq_read)
                head++;  // Popped on this edge
            drive_next_cycle();
        end
        repeat (3) @(posedge clk);
        if (DUT.u_props.fail_seen) begin
            $display("CHECK FAILED at time %0t: a dispatch property did not hold", $time);
            $display("TEST FAILED");
            $fatal(1, "property failure at end of run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    initial begin
        wait (DUT.u_props.fail_seen === 1'b1);
        $display("CHECK FAILED at time %0t: a dispatch property did not hold", $time);
        $display("TEST FAILED");
        $fatal(1, "property failure");
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run did not finish: %0d of %0d instructions issued in %0d cycles",
                 head, N_INSTR, TIMEOUT);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

/* verilog.f */
logic/isa_pkg.sv
logic/tomasulo_pkg.sv
logic/operand_bypass.sv
logic/instr_decoder.sv
logic/issue_control.sv
logic/issue_stage.sv
tests/issue_stage_properties.sv
tests/issue_stage_tb.sv
